// ==== dv/xadc_readout_assert.sv ====
`timescale 1ns/100ps

module xadc_readout_assert
(
    input logic clk200,
    input logic rst,
    input logic conv_start,
    input logic data_fifo_enable,
    input logic end_of_data,
    input logic xadc_busy
);

    int fail_cnt = 0;   // Read by the testbench summary

    conv_start_single: assert property (@(posedge clk200) disable iff (rst)
        conv_start |=> !conv_start)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("conv_start high for more than one cycle");
    end

    fifo_enable_single: assert property (@(posedge clk200) disable iff (rst)
        data_fifo_enable |=> !data_fifo_enable)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("data_fifo_enable high for more than one cycle");
    end

    // Frame end starts only on a write
    eod_with_enable: assert property (@(posedge clk200) disable iff (rst)
        $rose(end_of_data) |-> data_fifo_enable)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("end_of_data rose without data_fifo_enable");
    end

    busy_after_reset: assert property (@(posedge clk200)
        rst |=> !xadc_busy)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("xadc_busy high right after reset");
    end

endmodule

bind xadc_readout xadc_readout_assert u_xadc_readout_assert
(
    .clk200           (clk200),
    .rst              (rst),
    .conv_start       (conv_start),
    .data_fifo_enable (data_fifo_enable),
    .end_of_data      (end_of_data),
    .xadc_busy        (xadc_busy)
);

// ==== dv/xadc_readout_tb.sv ====
`timescale 1ns/100ps
`include "xadc_macros.svh"

module xadc_readout_tb;

    import xadc_data_pkg::*;

    // 940 samples at up to 16 cycles each make about 15000 cycles
    // The other tests stay under 2000, so this is a wide margin
    localparam int TIMEOUT_CYCLES = 60000;

    logic                       clk200;
    logic                       rst;
    logic                       data_in_rdy;
    logic [15:0]                vmm_id;
    logic [`XADC_SIZE_W-1:0]    sample_size;
    logic [`XADC_DELAY_W-1:0]   delay_in;
    logic                       udp_done;
    logic                       conv_done;
    sample_t                    conv_result;
    logic                       conv_start;
    vmm_sel_t                   conv_channel;
    fifo_word_t                 fifo_bus;
    logic                       data_fifo_enable;
    word_cnt_t                  packet_len;
    logic                       end_of_data;
    logic                       xadc_busy;

    int         cycle_cnt = 0;
    int         checks = 0;
    int         errors = 0;
    string      test_name = "reset";
    int         last_done = 0;
    bit         have_done = 0;
    bit         eod_write_prev = 0;    // Write cycle that ended a frame

    // Converter log and FIFO monitor
    sample_t    adc_res[$];
    vmm_sel_t   adc_chan[$];
    fifo_word_t got_words[$];
    word_cnt_t  got_lens[$];
    logic       got_eods[$];

    // Expected stream from the packing rules
    fifo_word_t exp_words[$];
    word_cnt_t  exp_lens[$];
    logic       exp_eods[$];
    vmm_sel_t   exp_chans[$];
    int         exp_frame;

    xadc_readout u_xadc_readout
    (
        .clk200           (clk200),
        .rst              (rst),
        .data_in_rdy      (data_in_rdy),
        .vmm_id           (vmm_id),
        .sample_size      (sample_size),
        .delay_in         (delay_in),
        .udp_done         (udp_done),
        .conv_done        (conv_done),
        .conv_result      (conv_result),
        .conv_start       (conv_start),
        .conv_channel     (conv_channel),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .xadc_busy        (xadc_busy)
    );

    always #4 clk200 = ~clk200;

    always @(posedge clk200)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("Timeout: no progress after %0d cycles in test %s", cycle_cnt, test_name);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ADC model and monitor
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int      lat;
        logic [31:0] rnd;
        void'($urandom(52652));
        forever
        begin
            @(negedge clk200);
            if (conv_start)
            begin
                lat = 3 + ($urandom % 8);   // 3 to 10 cycles
                rnd = $urandom;
                adc_res.push_back(rnd[`XADC_SAMPLE_W-1:0]);
                adc_chan.push_back(conv_channel);
                repeat (lat) @(posedge clk200);
                #1;
                conv_done   = 1'b1;
                conv_result = rnd[`XADC_SAMPLE_W-1:0];
                @(posedge clk200);
                #1;
                conv_done = 1'b0;
            end
        end
    end

    always @(negedge clk200)
    begin
        if (data_fifo_enable)
        begin
            got_words.push_back(fifo_bus);
            got_lens.push_back(packet_len);
            got_eods.push_back(end_of_data);
        end
        // end_of_data stays up for one cycle after a frame-ending write
        if (!data_fifo_enable && (end_of_data || eod_write_prev))
            check_bit($sformatf("%s end_of_data stretch", test_name),
                      eod_write_prev, end_of_data);
        eod_write_prev = data_fifo_enable && end_of_data;
        if (conv_start && have_done && (cycle_cnt - last_done) < delay_in + 1)
        begin
            $display("Test %s: conv_start came %0d cycles after conv_done, delay_in is %0d",
                     test_name, cycle_cnt - last_done, delay_in);
            errors++;
        end
        if (conv_done)
        begin
            last_done = cycle_cnt;
            have_done = 1'b1;
        end
        if (!xadc_busy)
            have_done = 1'b0;   // Spacing only counts inside one command
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input fifo_word_t exp, input fifo_word_t act);
        checks++;
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input word_cnt_t exp, input word_cnt_t act);
        checks++;
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_sel(input string name, input vmm_sel_t exp, input vmm_sel_t act);
        checks++;
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test helpers
    //////////////////////////////////////////////////////////////////////

    task automatic start_test(input string name);
        test_name = name;
        exp_frame = 0;
        adc_res.delete();
        adc_chan.delete();
        got_words.delete();
        got_lens.delete();
        got_eods.delete();
        exp_words.delete();
        exp_lens.delete();
        exp_eods.delete();
        exp_chans.delete();
    endtask

    task automatic send_command(input logic [15:0] id, input logic [`XADC_SIZE_W-1:0] size,
                                input logic [`XADC_DELAY_W-1:0] dly, input bit hold);
        @(posedge clk200);
        #1;
        vmm_id      = id;
        sample_size = size;
        delay_in    = dly;
        data_in_rdy = 1'b1;
        if (!hold)
        begin
            @(posedge clk200);
            #1;
            data_in_rdy = 1'b0;
        end
    endtask

    task automatic wait_idle();
        @(negedge clk200);
        while (xadc_busy)
            @(negedge clk200);
        repeat (5) @(negedge clk200);   // Room for a stray word
    endtask

    // Appends the words of one burst, five slots under the VMM nibble
    task automatic add_burst(input vmm_sel_t vmm, input int first, input int count);
        fifo_word_t w;
        int         slot;
        w    = '0;
        slot = 0;
        for (int i = 0; i < count; i++)
        begin
            exp_chans.push_back(vmm);
            w[slot*`XADC_SAMPLE_W +: `XADC_SAMPLE_W] = adc_res[first+i];
            slot++;
            if (slot == `XADC_SAMPLES_PER_WORD || i == count - 1)
            begin
                w[63:60] = {1'b0, vmm};
                exp_frame++;
                exp_words.push_back(w);
                exp_lens.push_back(word_cnt_t'(exp_frame));
                if (i == count - 1 || exp_frame == `XADC_MAX_WORDS)
                begin
                    exp_eods.push_back(1'b1);
                    exp_frame = 0;
                end
                else
                    exp_eods.push_back(1'b0);
                w    = '0;
                slot = 0;
            end
        end
    endtask

    task automatic compare_results();
        int n;
        check_len($sformatf("%s word count", test_name),
                  word_cnt_t'(exp_words.size()), word_cnt_t'(got_words.size()));
        n = (got_words.size() < exp_words.size()) ? got_words.size() : exp_words.size();
        for (int i = 0; i < n; i++)
        begin
            check_word($sformatf("%s word %0d", test_name, i + 1), exp_words[i], got_words[i]);
            check_len($sformatf("%s packet_len %0d", test_name, i + 1), exp_lens[i], got_lens[i]);
            check_bit($sformatf("%s end_of_data %0d", test_name, i + 1), exp_eods[i], got_eods[i]);
        end
        check_len($sformatf("%s conversion count", test_name),
                  word_cnt_t'(exp_chans.size()), word_cnt_t'(adc_chan.size()));
        n = (adc_chan.size() < exp_chans.size()) ? adc_chan.size() : exp_chans.size();
        for (int i = 0; i < n; i++)
            check_sel($sformatf("%s conv_channel %0d", test_name, i + 1), exp_chans[i], adc_chan[i]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic single_partial();
        start_test("single_partial");
        send_command(16'd3, 11'd7, 18'd2, 1'b0);
        wait_idle();
        check_len("single_partial words", word_cnt_t'(2), word_cnt_t'(got_words.size()));
        add_burst(3'd2, 0, 7);      // Second word has slots 2 to 4 empty
        compare_results();
    endtask

    task automatic single_exact();
        start_test("single_exact");
        send_command(16'd5, 11'd10, 18'd1, 1'b0);
        wait_idle();
        check_len("single_exact words", word_cnt_t'(2), word_cnt_t'(got_words.size()));
        add_burst(3'd4, 0, 10);
        compare_results();
    endtask

    task automatic all_vmms();
        start_test("all_vmms");
        send_command(16'd0, 11'd3, 18'd0, 1'b0);
        wait_idle();
        check_len("all_vmms words", word_cnt_t'(8), word_cnt_t'(got_words.size()));
        for (int v = 0; v < `XADC_VMM_COUNT; v++)
            add_burst(vmm_sel_t'(v), 3 * v, 3);
        compare_results();
    endtask

    task automatic frame_split();
        start_test("frame_split");
        send_command(16'd8, 11'd940, 18'd0, 1'b0);
        wait_idle();
        check_len("frame_split words", word_cnt_t'(188), word_cnt_t'(got_words.size()));
        add_burst(3'd7, 0, 940);    // Frame ends at 187, then one more word
        compare_results();
    endtask

    task automatic busy_release();
        start_test("busy_release");
        send_command(16'd1, 11'd4, 18'd20, 1'b1);   // Command level held
        while (got_words.size() < 1)
            @(negedge clk200);
        // Only the held command keeps busy up here
        repeat (10)
        begin
            @(negedge clk200);
            check_bit("busy_release busy with command held", 1'b1, xadc_busy);
        end
        // UDP side goes busy as the command drops
        @(posedge clk200);
        #1;
        udp_done    = 1'b0;
        data_in_rdy = 1'b0;
        repeat (10)
        begin
            @(negedge clk200);
            check_bit("busy_release busy before udp_done", 1'b1, xadc_busy);
        end
        // Second command while still busy
        @(posedge clk200);
        #1 data_in_rdy = 1'b1;
        @(posedge clk200);
        #1 data_in_rdy = 1'b0;
        repeat (10)
        begin
            @(negedge clk200);
            check_bit("busy_release busy after second command", 1'b1, xadc_busy);
        end
        @(posedge clk200);
        #1 udp_done = 1'b1;
        wait_idle();
        repeat (20) @(negedge clk200);
        check_len("busy_release conversions", word_cnt_t'(4), word_cnt_t'(adc_res.size()));
        add_burst(3'd0, 0, 4);
        compare_results();
    endtask

    initial
    begin
        int assert_fails;
        clk200      = 1'b0;
        rst         = 1'b1;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b1;
        conv_done   = 1'b0;
        conv_result = '0;
        repeat (3) @(posedge clk200);
        #1 rst = 1'b0;

        single_partial();
        single_exact();
        all_vmms();
        frame_split();
        busy_release();

        assert_fails = u_xadc_readout.u_xadc_readout_assert.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== hdl/conversion_ctrl.sv ====
`timescale 1ns/100ps

module conversion_ctrl
(
    input  logic                        clk200,
    input  logic                        rst,
    input  logic                        conv_req,
    input  xadc_data_pkg::vmm_sel_t     vmm_sel,
    input  logic                        conv_done,
    input  xadc_data_pkg::sample_t      conv_result,
    output logic                        conv_start,
    output xadc_data_pkg::vmm_sel_t     conv_channel,
    output logic                        sample_valid,
    output xadc_data_pkg::sample_t      sample
);

    import xadc_ctrl_pkg::*;

    conv_state_t state;

    assign conv_start = (state == cv_start);   // Single cycle by construction

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state        <= cv_idle;
            conv_channel <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;
            case (state)
                cv_idle:
                begin
                    if (conv_req)
                    begin
                        conv_channel <= vmm_sel;   // Held until the next request
                        state        <= cv_start;
                    end
                end

                cv_start: state <= cv_wait_done;

                cv_wait_done:
                begin
                    if (conv_done)
                    begin
                        sample_valid <= 1'b1;
                        state        <= cv_idle;
                    end
                end

                default: state <= cv_idle;
            endcase
        end
    end

    // Result register
    always_ff @(posedge clk200)
    begin
        if (state == cv_wait_done && conv_done)
            sample <= conv_result;
    end

endmodule

// ==== hdl/fifo_writer.sv ====
`timescale 1ns/100ps
`include "xadc_macros.svh"

module fifo_writer
(
    input  logic                        clk200,
    input  logic                        rst,
    input  logic                        word_valid,
    input  xadc_data_pkg::fifo_word_t   word,
    input  logic                        word_last,
    output xadc_data_pkg::fifo_word_t   fifo_bus,
    output logic                        data_fifo_enable,
    output xadc_data_pkg::word_cnt_t    packet_len,
    output logic                        end_of_data,
    output logic                        burst_written
);

    import xadc_ctrl_pkg::*;
    import xadc_data_pkg::*;

    wr_state_t  state;
    word_cnt_t  frame_cnt;     // Words already in this frame
    word_cnt_t  cnt_next;
    logic       frame_end;
    logic       frame_end_r;
    logic       last_r;

    assign cnt_next  = frame_cnt + 1'b1;
    assign frame_end = word_last || (cnt_next == `XADC_MAX_WORDS);

    assign data_fifo_enable = (state == wr_write);
    // Two cycles so the slower UDP clock domain sees it
    assign end_of_data      = (state == wr_write && frame_end_r) || (state == wr_hold);
    assign burst_written    = (state == wr_write && last_r);

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state       <= wr_idle;
            frame_cnt   <= '0;
            packet_len  <= '0;
            frame_end_r <= 1'b0;
            last_r      <= 1'b0;
        end
        else if (word_valid)
        begin
            packet_len  <= cnt_next;
            frame_end_r <= frame_end;
            last_r      <= word_last;
            frame_cnt   <= frame_end ? '0 : cnt_next;   // Next word restarts at 1
            state       <= wr_write;
        end
        else
        begin
            case (state)
                wr_write: state <= frame_end_r ? wr_hold : wr_idle;
                wr_hold:  state <= wr_idle;
                default:  state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk200)
    begin
        if (word_valid)
            fifo_bus <= word;
    end

endmodule

// ==== hdl/packet_packer.sv ====
`timescale 1ns/100ps
`include "xadc_macros.svh"

module packet_packer
(
    input  logic                        clk200,
    input  logic                        rst,
    input  logic                        sample_valid,
    input  xadc_data_pkg::sample_t      sample,
    input  logic                        sample_last,
    input  xadc_data_pkg::vmm_sel_t     vmm_sel,
    output logic                        word_valid,
    output xadc_data_pkg::fifo_word_t   word,
    output logic                        word_last
);

    import xadc_data_pkg::*;

    fifo_word_t acc;        // Word under construction
    fifo_word_t next_word;
    slot_t      fill;
    logic       word_done;

    // Current word with the incoming sample dropped into its slot
    always_comb
    begin
        next_word = acc;
        next_word[63:60] = {1'b0, vmm_sel};
        next_word[fill*`XADC_SAMPLE_W +: `XADC_SAMPLE_W] = sample;
    end

    assign word_done = (fill == `XADC_SAMPLES_PER_WORD - 1) || sample_last;

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            acc        <= '0;
            fill       <= '0;
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end
        else
        begin
            word_valid <= 1'b0;
            if (sample_valid)
            begin
                if (word_done)
                begin
                    word       <= next_word;
                    word_last  <= sample_last;
                    word_valid <= 1'b1;
                    acc        <= '0;       // Unused slots stay zero
                    fill       <= '0;
                end
                else
                begin
                    acc  <= next_word;
                    fill <= fill + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/sample_sequencer.sv ====
`timescale 1ns/100ps
`include "xadc_macros.svh"

module sample_sequencer
(
    input  logic                        clk200,
    input  logic                        rst,
    input  logic                        data_in_rdy,
    input  logic [15:0]                 vmm_id,
    input  logic [`XADC_SIZE_W-1:0]     sample_size,
    input  logic [`XADC_DELAY_W-1:0]    delay_in,
    input  logic                        udp_done,
    input  logic                        sample_valid,
    input  logic                        burst_written,
    output logic                        conv_req,
    output logic                        sample_last,
    output xadc_data_pkg::vmm_sel_t     vmm_sel,
    output logic                        xadc_busy
);

    import xadc_ctrl_pkg::*;

    seq_state_t                 state;
    logic                       all_mode;   // Loop over every VMM
    logic [3:0]                 id_low;
    logic [`XADC_SIZE_W-1:0]    req_cnt;
    logic [`XADC_SIZE_W-1:0]    req_next;
    logic [`XADC_SIZE_W-1:0]    size_eff;
    logic [`XADC_DELAY_W-1:0]   delay_cnt;

    assign id_low   = vmm_id[3:0] - 4'd1;   // Ids count from 1
    assign req_next = req_cnt + 1'b1;
    // A size of zero still takes one sample
    assign size_eff = (sample_size == '0) ? {{(`XADC_SIZE_W-1){1'b0}}, 1'b1} : sample_size;

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state       <= seq_idle;
            conv_req    <= 1'b0;
            sample_last <= 1'b0;
            vmm_sel     <= '0;
            all_mode    <= 1'b0;
            xadc_busy   <= 1'b0;
            req_cnt     <= '0;
            delay_cnt   <= '0;
        end
        else
        begin
            conv_req <= 1'b0;
            case (state)
                seq_idle:
                begin
                    if (data_in_rdy)
                    begin
                        xadc_busy <= 1'b1;
                        req_cnt   <= '0;
                        if (vmm_id == 16'd0 || id_low > `XADC_VMM_COUNT)
                        begin
                            all_mode <= 1'b1;
                            vmm_sel  <= '0;     // Stepped after each burst
                        end
                        else
                        begin
                            all_mode <= 1'b0;
                            vmm_sel  <= id_low[2:0];
                        end
                        state <= seq_request;
                    end
                end

                seq_request:
                begin
                    conv_req    <= 1'b1;
                    req_cnt     <= req_next;
                    sample_last <= (req_next >= size_eff);  // Tags the burst's final sample
                    state       <= seq_wait_sample;
                end

                seq_wait_sample:
                begin
                    if (sample_valid)
                    begin
                        if (sample_last)
                            state <= seq_wait_written;
                        else
                        begin
                            delay_cnt <= '0;
                            state     <= seq_delay;
                        end
                    end
                end

                seq_delay:     // delay_in+1 idle cycles
                begin
                    if (delay_cnt == delay_in)
                        state <= seq_request;
                    else
                        delay_cnt <= delay_cnt + 1'b1;
                end

                seq_wait_written:
                begin
                    if (burst_written)
                    begin
                        req_cnt <= '0;
                        if (all_mode && vmm_sel != `XADC_VMM_COUNT - 1)
                        begin
                            vmm_sel   <= vmm_sel + 1'b1;
                            delay_cnt <= '0;
                            state     <= seq_delay;     // Same spacing across VMMs
                        end
                        else
                            state <= seq_wait_release;
                    end
                end

                seq_wait_release:  // Old command gone and UDP frame sent
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= seq_idle;
                    end
                end

                default: state <= seq_idle;
            endcase
        end
    end

endmodule

// ==== hdl/xadc_ctrl_pkg.sv ====
package xadc_ctrl_pkg;

    // Main burst sequencer
    typedef enum logic [2:0]
    {
        seq_idle,
        seq_request,
        seq_wait_sample,
        seq_delay,
        seq_wait_written,
        seq_wait_release
    } seq_state_t;

    // One conversion handshake
    typedef enum logic [1:0]
    {
        cv_idle,
        cv_start,
        cv_wait_done
    } conv_state_t;

    // FIFO write and end_of_data stretch
    typedef enum logic [1:0]
    {
        wr_idle,
        wr_write,
        wr_hold
    } wr_state_t;

endpackage

// ==== hdl/xadc_data_pkg.sv ====
`include "xadc_macros.svh"

package xadc_data_pkg;

    typedef logic [`XADC_SAMPLE_W-1:0] sample_t;

    // Header nibble in 63:60, slot k at 12k+11 down to 12k
    typedef logic [63:0] fifo_word_t;

    typedef logic [2:0]  vmm_sel_t;   // VMM index 0 to 7

    typedef logic [11:0] word_cnt_t;  // packet_len

    typedef logic [2:0]  slot_t;      // Fill index 0 to 4

endpackage

// ==== hdl/xadc_macros.svh ====
`ifndef XADC_MACROS_SVH
`define XADC_MACROS_SVH

// Converter and packing geometry
`define XADC_SAMPLE_W          12
`define XADC_SAMPLES_PER_WORD  5

// Frame and VMM limits
`define XADC_MAX_WORDS         187  // Words per UDP frame
`define XADC_VMM_COUNT         8

// Command field widths
`define XADC_SIZE_W            11
`define XADC_DELAY_W           18

`endif

// ==== hdl/xadc_readout.sv ====
`timescale 1ns/100ps
`include "xadc_macros.svh"

module xadc_readout
(
    input  logic                        clk200,
    input  logic                        rst,
    input  logic                        data_in_rdy,
    input  logic [15:0]                 vmm_id,
    input  logic [`XADC_SIZE_W-1:0]     sample_size,
    input  logic [`XADC_DELAY_W-1:0]    delay_in,
    input  logic                        udp_done,
    input  logic                        conv_done,
    input  xadc_data_pkg::sample_t      conv_result,
    output logic                        conv_start,
    output xadc_data_pkg::vmm_sel_t     conv_channel,
    output xadc_data_pkg::fifo_word_t   fifo_bus,
    output logic                        data_fifo_enable,
    output xadc_data_pkg::word_cnt_t    packet_len,
    output logic                        end_of_data,
    output logic                        xadc_busy
);

    import xadc_data_pkg::*;

    logic       conv_req;
    vmm_sel_t   vmm_sel;
    logic       sample_valid;
    sample_t    sample;
    logic       sample_last;
    logic       word_valid;
    fifo_word_t word;
    logic       word_last;
    logic       burst_written;

    //////////////////////////////////////////////////////////////////////
    // Control path
    //////////////////////////////////////////////////////////////////////

    sample_sequencer u_sample_sequencer
    (
        .clk200        (clk200),
        .rst           (rst),
        .data_in_rdy   (data_in_rdy),
        .vmm_id        (vmm_id),
        .sample_size   (sample_size),
        .delay_in      (delay_in),
        .udp_done      (udp_done),
        .sample_valid  (sample_valid),
        .burst_written (burst_written),
        .conv_req      (conv_req),
        .sample_last   (sample_last),
        .vmm_sel       (vmm_sel),
        .xadc_busy     (xadc_busy)
    );

    conversion_ctrl u_conversion_ctrl
    (
        .clk200       (clk200),
        .rst          (rst),
        .conv_req     (conv_req),
        .vmm_sel      (vmm_sel),
        .conv_done    (conv_done),
        .conv_result  (conv_result),
        .conv_start   (conv_start),
        .conv_channel (conv_channel),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    //////////////////////////////////////////////////////////////////////
    // Data path to the FIFO
    //////////////////////////////////////////////////////////////////////

    packet_packer u_packet_packer
    (
        .clk200       (clk200),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .sample_last  (sample_last),
        .vmm_sel      (vmm_sel),
        .word_valid   (word_valid),
        .word         (word),
        .word_last    (word_last)
    );

    fifo_writer u_fifo_writer
    (
        .clk200           (clk200),
        .rst              (rst),
        .word_valid       (word_valid),
        .word             (word),
        .word_last        (word_last),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .burst_written    (burst_written)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module xadc_readout_tb -f vlog.f

sim_out=$(./obj_dir/Vxadc_readout_tb) || true
echo "$sim_out"

if grep -Fqx "=== PASS ===" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== vlog.f ====
+incdir+hdl
hdl/xadc_ctrl_pkg.sv
hdl/xadc_data_pkg.sv
hdl/sample_sequencer.sv
hdl/conversion_ctrl.sv
hdl/packet_packer.sv
hdl/fifo_writer.sv
hdl/xadc_readout.sv
dv/xadc_readout_assert.sv
dv/xadc_readout_tb.sv
